// ==== filelist.f ====
+incdir+source
source/corePkg.sv
source/control.sv
source/regFile.sv
source/decodeStage.sv
source/aluExec.sv
source/resultStage.sv
source/miniCore.sv
verif/coreTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds coreTb with Verilator, runs it, and judges the run from its log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f filelist.f --top-module coreTb -Mdir obj_dir -o coreTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/coreTb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

// ==== verif/coreTb.sv ====
// Random 16-bit words with HALT only as the last word; model assumes 16-bit data and 8 registers
`timescale 1ns/10ps
`include "coreCfg.svh"

module coreTb import corePkg::*; ();

    localparam int NumInstr   = 600;    // Main random program
    localparam int NumInstr2  = 40;     // Short program after the second reset
    localparam int AW         = $clog2(`CORE_DMEM_WORDS);
    localparam int WatchdogNs = (NumInstr + NumInstr2) * 3 * 20 + 2000; // 3 cycles per word worst

    logic   clk;
    logic   rstN;
    logic   instrValid;
    instrU  instr;
    logic   retValid;
    retireT retire;
    logic   halted;

    int     seed = 32'h7dd1_55ca;
    wordT   mRegs [`CORE_NREGS];       // Model registers
    wordT   mMem  [`CORE_DMEM_WORDS];  // Model data memory
    wordT   mPc;
    logic   mHalted;
    logic   expValid;                  // Retire due at next sample
    logic   expMem;                    // Pending retire is a memory op
    retireT expRet;

    miniCore u_dut (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .retValid   (retValid),
        .retire     (retire),
        .halted     (halted)
    );

    always #10 clk = ~clk;

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            stopRun($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic wordT rotl(input wordT v, input logic [3:0] s);
        return (v << s) | (v >> (`CORE_XLEN - int'(s)));
    endfunction

    function automatic wordT rotr(input wordT v, input logic [3:0] s);
        return (v >> s) | (v << (`CORE_XLEN - int'(s)));
    endfunction

    task automatic writeBack(input logic [2:0] r, input wordT v);
        expRet.wbEn   = 1'b1;
        expRet.wbReg  = r;
        expRet.wbData = v;
    endtask

    // Predicts one retire record and updates the model state
    task automatic applyModel(input logic [15:0] w);
        logic [2:0]    rs;
        logic [2:0]    rb;
        logic [2:0]    rdR;
        wordT          a;
        wordT          b;
        wordT          imm5s;
        wordT          imm5z;
        wordT          imm8s;
        wordT          disp;
        wordT          pc2;
        wordT          addr;
        wordT          rev;
        logic [16:0]   sum;
        logic [AW-1:0] idx;
        rs    = w[10:8];
        rb    = w[7:5];                 // Rt in R format, Rd in I format 1
        rdR   = w[4:2];
        a     = mRegs[rs];
        b     = mRegs[rb];
        imm5s = {{11{w[4]}}, w[4:0]};
        imm5z = {11'b0, w[4:0]};
        imm8s = {{8{w[7]}}, w[7:0]};
        disp  = {{5{w[10]}}, w[10:0]};
        pc2   = mPc + 16'd2;
        addr  = a + imm5s;
        idx   = addr[AW:1];             // Word index
        sum   = {1'b0, a} + {1'b0, b};
        rev   = {<<{a}};
        expRet        = '0;
        expMem        = 1'b0;
        expRet.pc     = mPc;
        expRet.nextPc = pc2;
        case (w[15:11])
            ADDI:  writeBack(rb, a + imm5s);
            SUBI:  writeBack(rb, imm5s - a);
            XORI:  writeBack(rb, a ^ imm5z);
            ANDNI: writeBack(rb, a & ~imm5z);
            ROLI:  writeBack(rb, rotl(a, w[3:0]));
            SLLI:  writeBack(rb, a << w[3:0]);
            RORI:  writeBack(rb, rotr(a, w[3:0]));
            SRLI:  writeBack(rb, a >> w[3:0]);
            ARR:   writeBack(rdR, w[1] ? (w[0] ? a & ~b : a ^ b) : (w[0] ? b - a : a + b));
            SHR:   writeBack(rdR, w[1] ? (w[0] ? a >> b[3:0] : rotr(a, b[3:0]))
                                       : (w[0] ? a << b[3:0] : rotl(a, b[3:0])));
            SEQ:   writeBack(rdR, wordT'(a == b));
            SLT:   writeBack(rdR, wordT'($signed(a) < $signed(b)));
            SLE:   writeBack(rdR, wordT'($signed(a) <= $signed(b)));
            SCO:   writeBack(rdR, wordT'(sum[16]));
            BTR:   writeBack(rdR, rev);
            LBI:   writeBack(rs, imm8s);
            SLBI:  writeBack(rs, {a[7:0], w[7:0]});
            ST, LD, STU: begin
                expMem         = 1'b1;
                expRet.memAddr = addr;
                if (w[15:11] == LD) begin
                    expRet.memData = mMem[idx];
                    writeBack(rb, mMem[idx]);
                end else begin
                    expRet.memWr   = 1'b1;
                    expRet.memData = b;  // Store data is Rd
                    if (w[15:11] == STU) begin
                        writeBack(rs, addr);
                    end
                end
            end
            BEQZ:  expRet.nextPc = (a == 16'd0) ? pc2 + imm8s : pc2;
            BNEZ:  expRet.nextPc = (a != 16'd0) ? pc2 + imm8s : pc2;
            BLTZ:  expRet.nextPc = a[15] ? pc2 + imm8s : pc2;
            BGEZ:  expRet.nextPc = a[15] ? pc2 : pc2 + imm8s;
            J:     expRet.nextPc = pc2 + disp;
            JR:    expRet.nextPc = a + imm8s;
            JAL: begin
                expRet.nextPc = pc2 + disp;
                writeBack(3'd7, pc2);   // Link in R7
            end
            JALR: begin
                expRet.nextPc = a + imm8s;
                writeBack(3'd7, pc2);
            end
            HALT:  expRet.halt = 1'b1;
            default: ;                  // NOP, SIIC, RTI
        endcase
        if (expRet.wbEn) begin
            mRegs[expRet.wbReg] = expRet.wbData;
        end
        if (expRet.memWr) begin
            mMem[idx] = b;
        end
        if (expRet.halt) begin
            mHalted = 1'b1;
        end
        mPc = expRet.nextPc;
    endtask

    task automatic checkOutputs();
        check("retValid", wordT'(retValid), wordT'(expValid));
        check("halted", wordT'(halted), wordT'(mHalted));
        if (expValid) begin
            check("retire.pc", retire.pc, expRet.pc);
            check("retire.nextPc", retire.nextPc, expRet.nextPc);
            check("retire.wbEn", wordT'(retire.wbEn), wordT'(expRet.wbEn));
            check("retire.memWr", wordT'(retire.memWr), wordT'(expRet.memWr));
            check("retire.memData", retire.memData, expRet.memData);
            check("retire.halt", wordT'(retire.halt), wordT'(expRet.halt));
            if (expRet.wbEn) begin
                check("retire.wbReg", wordT'(retire.wbReg), wordT'(expRet.wbReg));
                check("retire.wbData", retire.wbData, expRet.wbData);
            end
            if (expMem) begin
                check("retire.memAddr", retire.memAddr, expRet.memAddr);
            end
        end
    endtask

    // Checks the previous cycle's strobe, then drives the next one
    task automatic stepCycle(input logic valid, input logic [15:0] word);
        @(posedge clk);
        #2;
        checkOutputs();
        instrValid = valid;
        instr      = word;
        expValid   = valid & ~mHalted; // Strobe while halted is dropped
        if (expValid) begin
            applyModel(word);
        end
    endtask

    task automatic resetCore();
        rstN       = 1'b0;
        instrValid = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rstN = 1'b1;
        for (int r = 0; r < `CORE_NREGS; r++) begin
            mRegs[r] = '0;
        end
        for (int m = 0; m < `CORE_DMEM_WORDS; m++) begin
            mMem[m] = '0;
        end
        mPc      = '0;
        mHalted  = 1'b0;
        expValid = 1'b0;
    endtask

    task automatic runProgram(input int count);
        logic [31:0] r;
        logic [15:0] w;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            w = r[15:0];
            if (i == count - 1) begin
                w[15:11] = HALT;
            end else if (w[15:11] == HALT) begin
                w[15:11] = NOP;
            end
            stepCycle(1'b1, w);
            if (r[19:18] == 2'b00) begin
                for (int g = 0; g < 1 + int'(r[17]); g++) begin
                    stepCycle(1'b0, r[31:16]); // Idle gap with junk on instr
                end
            end
        end
        for (int i = 0; i < 3; i++) begin
            r = $random(seed);
            stepCycle(1'b1, r[15:0]);   // Core is halted by now
        end
        stepCycle(1'b0, '0);
    endtask

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        expValid   = 1'b0;
        resetCore();
        runProgram(NumInstr);
        resetCore();                    // Clears halted, PC, registers and memory
        runProgram(NumInstr2);
        $display("Regression passed");
        $finish;
    end

    initial begin
        #(WatchdogNs);
        stopRun($sformatf("Timeout: the run did not finish within %0d ns", WatchdogNs));
    end

endmodule

// ==== source/miniCore.sv ====
// Single-cycle core with no back-pressure; each accepted strobe retires exactly one cycle later
`timescale 1ns/10ps

module miniCore import corePkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   instrValid,
    input  instrU  instr,
    output logic   retValid,
    output retireT retire,
    output logic   halted
);

    wordT    pc;
    regIdxT  rdAddrA;
    regIdxT  rdAddrB;
    wordT    rdDataA;
    wordT    rdDataB;
    ctrlT    ctrl;
    operandT opnd;
    execResT exRes;
    logic    wrEn;
    regIdxT  wrAddr;
    wordT    wrData;

    regFile uRegFile (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData)
    );

    decodeStage uDecode (
        .instr   (instr),
        .pc      (pc),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .ctrl    (ctrl),
        .opnd    (opnd)
    );

    aluExec uExec (
        .ctrl  (ctrl),
        .opnd  (opnd),
        .exRes (exRes)
    );

    resultStage uResult (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .ctrl       (ctrl),
        .opnd       (opnd),
        .exRes      (exRes),
        .pc         (pc),
        .wrEn       (wrEn),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .retValid   (retValid),
        .retire     (retire),
        .halted     (halted)
    );

endmodule

// ==== source/resultStage.sv ====
// Commits only on a strobe while not halted; halted clears only on reset, data memory clears on reset
`timescale 1ns/10ps
`include "coreCfg.svh"

module resultStage import corePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    instrValid,
    input  ctrlT    ctrl,
    input  operandT opnd,
    input  execResT exRes,
    output wordT    pc,
    output logic    wrEn,
    output regIdxT  wrAddr,
    output wordT    wrData,
    output logic    retValid,
    output retireT  retire,
    output logic    halted
);

    localparam int AW = $clog2(`CORE_DMEM_WORDS);

    wordT          dmem [`CORE_DMEM_WORDS];
    logic          commit;
    logic [AW-1:0] memIdx;
    wordT          memRdData;

    assign commit    = instrValid & ~halted;
    assign memIdx    = exRes.aluOut[AW:1];  // Word index, byte bit 0 ignored
    assign memRdData = ctrl.memEnable ? dmem[memIdx] : '0;

    // Write-back select
    always_comb begin
        case (ctrl.linkReg)
            2'b10:   wrData = exRes.pcPlus2; // JAL and JALR return address
            default: wrData = ctrl.val2Reg ? memRdData : exRes.aluOut;
        endcase
    end

    assign wrEn   = commit & ctrl.regWrite;
    assign wrAddr = opnd.destReg;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int w = 0; w < `CORE_DMEM_WORDS; w++) begin
                dmem[w] <= '0;
            end
        end else if (commit && ctrl.memWr) begin
            dmem[memIdx] <= exRes.storeData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc       <= '0;
            halted   <= 1'b0;
            retValid <= 1'b0;
        end else begin
            retValid <= commit;         // One pulse per committed strobe
            if (commit) begin
                pc <= exRes.nextPc;
                if (ctrl.halt) begin
                    halted <= 1'b1;     // Sticky until reset
                end
            end
        end
    end

    // Retire record, qualified by retValid
    always_ff @(posedge clk) begin
        if (commit) begin
            retire <= '{pc:      opnd.pc,
                        nextPc:  exRes.nextPc,
                        wbEn:    ctrl.regWrite,
                        wbReg:   opnd.destReg,
                        wbData:  wrData,
                        memWr:   ctrl.memWr,
                        memAddr: exRes.aluOut,
                        memData: ctrl.memWr ? exRes.storeData : memRdData,
                        halt:    ctrl.halt};
        end
    end

endmodule

// ==== source/aluExec.sv ====
// SUB and SUBI subtract Rs from the other operand; shift and rotate use only the low 4 amount bits
`timescale 1ns/10ps
`include "coreCfg.svh"

module aluExec import corePkg::*; (
    input  ctrlT    ctrl,
    input  operandT opnd,
    output execResT exRes
);

    wordT                     opB;
    wordT                     aluOut;
    wordT                     pcPlus2;
    wordT                     jmpBase;
    logic [1:0]               subOp;
    logic [3:0]               shAmt;
    logic [2*`CORE_XLEN-1:0]  rolW;
    logic [2*`CORE_XLEN-1:0]  rorW;
    logic [`CORE_XLEN:0]      sumCo;

    assign opB   = ctrl.aluSel ? opnd.imm : opnd.rtVal;
    assign subOp = ctrl.aluSel ? ctrl.aluCntrl[1:0] : opnd.func; // Same op order in both formats
    assign shAmt = opB[3:0];
    assign rolW  = {opnd.rsVal, opnd.rsVal} << shAmt; // Upper half is the rotate left
    assign rorW  = {opnd.rsVal, opnd.rsVal} >> shAmt; // Lower half is the rotate right
    assign sumCo = {1'b0, opnd.rsVal} + {1'b0, opnd.rtVal};

    always_comb begin
        aluOut = opnd.rsVal + opB;      // Memory and jump ops act as ADDI
        casez (ctrl.aluCntrl)
            5'b010??, ARR: begin
                case (subOp)
                    2'b00:   aluOut = opnd.rsVal + opB;
                    2'b01:   aluOut = opB - opnd.rsVal;
                    2'b10:   aluOut = opnd.rsVal ^ opB;
                    default: aluOut = opnd.rsVal & ~opB; // ANDN
                endcase
            end
            5'b101??, SHR: begin
                case (subOp)
                    2'b00:   aluOut = rolW[2*`CORE_XLEN-1:`CORE_XLEN];
                    2'b01:   aluOut = opnd.rsVal << shAmt;
                    2'b10:   aluOut = rorW[`CORE_XLEN-1:0];
                    default: aluOut = opnd.rsVal >> shAmt; // Logical right
                endcase
            end
            LBI:  aluOut = opnd.imm;
            SLBI: aluOut = {opnd.rsVal[7:0], opnd.imm[7:0]};
            BTR: begin
                for (int b = 0; b < `CORE_XLEN; b++) begin
                    aluOut[b] = opnd.rsVal[`CORE_XLEN-1-b];
                end
            end
            SEQ:  aluOut = wordT'(opnd.rsVal == opnd.rtVal);
            SLT:  aluOut = wordT'($signed(opnd.rsVal) < $signed(opnd.rtVal));
            SLE:  aluOut = wordT'($signed(opnd.rsVal) <= $signed(opnd.rtVal));
            SCO:  aluOut = wordT'(sumCo[`CORE_XLEN]); // Carry out of Rs + Rt
            default: ;
        endcase
    end

    // Next PC
    assign pcPlus2 = opnd.pc + wordT'(2);
    assign jmpBase = ctrl.regJmp ? opnd.rsVal : pcPlus2;

    assign exRes = '{aluOut:    aluOut,
                     storeData: opnd.rtVal,
                     pcPlus2:   pcPlus2,
                     nextPc:    ctrl.pcSel ? jmpBase + opnd.imm : pcPlus2};

endmodule

// ==== source/decodeStage.sv ====
// Combinational stage; port B always reads bits [7:5], which is Rt in R format and Rd in I format 1
`timescale 1ns/10ps
`include "coreCfg.svh"

module decodeStage import corePkg::*; (
    input  instrU   instr,
    input  wordT    pc,
    input  wordT    rdDataA,
    input  wordT    rdDataB,
    output regIdxT  rdAddrA,
    output regIdxT  rdAddrB,
    output ctrlT    ctrl,
    output operandT opnd
);

    logic   zFlag;
    logic   sFlag;
    wordT   immExt;
    regIdxT destReg;

    assign rdAddrA = instr.rFmt.rs;
    assign rdAddrB = instr.rFmt.rt;     // Also the store data register

    assign zFlag = (rdDataA == '0);
    assign sFlag = rdDataA[`CORE_XLEN-1];

    control uControl (
        .opcode (instr.rFmt.opcode),
        .zFlag  (zFlag),
        .sFlag  (sFlag),
        .ctrl   (ctrl)
    );

    // Fill bit is the immediate MSB only when sign extension is asked for
    always_comb begin
        case (ctrl.immSel[1:0])
            2'b00:   immExt = {{(`CORE_XLEN-5){ctrl.immSel[2] & instr.i1Fmt.imm[4]}},
                               instr.i1Fmt.imm};
            2'b01:   immExt = {{(`CORE_XLEN-8){ctrl.immSel[2] & instr.i2Fmt.imm[7]}},
                               instr.i2Fmt.imm};
            default: immExt = {{(`CORE_XLEN-11){ctrl.immSel[2] & instr.jFmt.disp[10]}},
                               instr.jFmt.disp};
        endcase
    end

    always_comb begin
        case (ctrl.destRegSel)
            2'b00:   destReg = instr.rFmt.rs;
            2'b01:   destReg = instr.rFmt.rd;
            2'b10:   destReg = regIdxT'(`CORE_NREGS - 1); // Link register R7
            default: destReg = instr.i1Fmt.rd;
        endcase
    end

    assign opnd = '{rsVal: rdDataA, rtVal: rdDataB, imm: immExt, destReg: destReg,
                    func: instr.rFmt.func, pc: pc};

endmodule

// ==== source/regFile.sv ====
// All registers clear on reset, R0 is an ordinary register, a same-cycle read returns the old value
`timescale 1ns/10ps
`include "coreCfg.svh"

module regFile import corePkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  regIdxT rdAddrA,
    input  regIdxT rdAddrB,
    output wordT   rdDataA,
    output wordT   rdDataB,
    input  logic   wrEn,
    input  regIdxT wrAddr,
    input  wordT   wrData
);

    wordT regs [`CORE_NREGS];

    assign rdDataA = regs[rdAddrA]; // Combinational read ports
    assign rdDataB = regs[rdAddrB];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int r = 0; r < `CORE_NREGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData; // Single write port
        end
    end

endmodule

// ==== source/control.sv ====
// Pure combinational decode; SIIC and RTI decode as NOP and every 5-bit opcode has a defined row
`timescale 1ns/10ps

module control import corePkg::*; (
    input  opcodeE opcode,
    input  logic   zFlag,   // Rs is zero
    input  logic   sFlag,   // Rs is negative
    output ctrlT   ctrl
);

    always_comb begin
        // Defaults describe a harmless I-format 1 op with no side effects
        ctrl            = '0;
        ctrl.destRegSel = 2'b11;        // Rd-I
        ctrl.aluCntrl   = opcode;       // ALU sees the raw opcode
        ctrl.aluSel     = 1'b1;         // Immediate operand
        ctrl.immSel     = 3'b100;       // Sign extend 5 bits

        casez (opcode)
            5'b000??: begin
                ctrl.halt = (opcode == HALT); // NOP, SIIC, RTI fall through
            end
            5'b010??, 5'b101??: begin   // ALU immediate ops and shifts
                ctrl.regWrite = 1'b1;
                ctrl.immSel   = opcode[1] ? 3'b000 : 3'b100; // XORI, ANDNI, RORI, SRLI zero extend
            end
            5'b1000?: begin             // ST and LD
                ctrl.memEnable = 1'b1;
                ctrl.aluCntrl  = ADDI;  // Address is Rs + imm
                if (opcode[0]) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.val2Reg  = 1'b1; // Load data to Rd
                end else begin
                    ctrl.memWr = 1'b1;
                end
            end
            5'b10011: begin             // STU
                ctrl.memEnable  = 1'b1;
                ctrl.memWr      = 1'b1;
                ctrl.regWrite   = 1'b1;
                ctrl.destRegSel = 2'b00; // Address goes back to Rs
                ctrl.aluCntrl   = ADDI;
            end
            5'b11001, 5'b1101?, 5'b111??: begin // R format, LBI excluded
                ctrl.regWrite   = 1'b1;
                ctrl.aluSel     = 1'b0;
                ctrl.destRegSel = 2'b01;
                ctrl.immSel     = 3'b000;
            end
            5'b011??: begin             // Branches on Rs
                ctrl.immSel = 3'b101;   // Sign extend 8 bits
                case (opcode[1:0])
                    2'b00:   ctrl.pcSel = zFlag;  // BEQZ
                    2'b01:   ctrl.pcSel = ~zFlag; // BNEZ
                    2'b10:   ctrl.pcSel = sFlag;  // BLTZ
                    default: ctrl.pcSel = ~sFlag; // BGEZ
                endcase
            end
            5'b11000: begin             // LBI
                ctrl.regWrite   = 1'b1;
                ctrl.destRegSel = 2'b00;
                ctrl.immSel     = 3'b101;
                ctrl.linkReg    = 2'b01;
            end
            5'b10010: begin             // SLBI
                ctrl.regWrite   = 1'b1;
                ctrl.destRegSel = 2'b00;
                ctrl.immSel     = 3'b001; // Zero extend 8 bits
            end
            5'b001??: begin             // J, JR, JAL, JALR
                ctrl.pcSel    = 1'b1;
                ctrl.regJmp   = opcode[0]; // JR and JALR use Rs
                ctrl.immSel   = opcode[0] ? 3'b101 : 3'b110;
                ctrl.aluCntrl = ADDI;
                if (opcode[1]) begin    // Link variants
                    ctrl.regWrite   = 1'b1;
                    ctrl.destRegSel = 2'b10; // R7
                    ctrl.linkReg    = 2'b10;
                end
            end
            default: ;                  // Unreachable, all patterns listed
        endcase
    end

endmodule

// ==== source/corePkg.sv ====
// Opcode values follow the 5-bit teaching ISA; instrU assumes a 16-bit word with 3-bit register fields
`include "coreCfg.svh"

package corePkg;

    typedef logic [`CORE_XLEN-1:0] wordT;
    typedef logic [$clog2(`CORE_NREGS)-1:0] regIdxT;

    typedef enum logic [4:0] {
        HALT  = 5'b00000, NOP   = 5'b00001, SIIC  = 5'b00010, RTI   = 5'b00011,
        J     = 5'b00100, JR    = 5'b00101, JAL   = 5'b00110, JALR  = 5'b00111,
        ADDI  = 5'b01000, SUBI  = 5'b01001, XORI  = 5'b01010, ANDNI = 5'b01011,
        BEQZ  = 5'b01100, BNEZ  = 5'b01101, BLTZ  = 5'b01110, BGEZ  = 5'b01111,
        ST    = 5'b10000, LD    = 5'b10001, SLBI  = 5'b10010, STU   = 5'b10011,
        ROLI  = 5'b10100, SLLI  = 5'b10101, RORI  = 5'b10110, SRLI  = 5'b10111,
        LBI   = 5'b11000, BTR   = 5'b11001, SHR   = 5'b11010, ARR   = 5'b11011,
        SEQ   = 5'b11100, SLT   = 5'b11101, SLE   = 5'b11110, SCO   = 5'b11111
    } opcodeE;

    // Same 16 bits seen through each instruction format
    typedef union packed {
        struct packed {
            opcodeE     opcode;
            logic [2:0] rs;
            logic [2:0] rt;
            logic [2:0] rd;
            logic [1:0] func;   // Selects op within SHR and ARR
        } rFmt;
        struct packed {
            opcodeE     opcode;
            logic [2:0] rs;
            logic [2:0] rd;
            logic [4:0] imm;
        } i1Fmt;
        struct packed {
            opcodeE     opcode;
            logic [2:0] rs;
            logic [7:0] imm;
        } i2Fmt;
        struct packed {
            opcodeE      opcode;
            logic [10:0] disp;
        } jFmt;
    } instrU;

    typedef struct packed {
        logic       regWrite;   // Register file write
        logic [1:0] destRegSel; // 00 Rs, 01 Rd-R, 10 R7, 11 Rd-I
        logic       pcSel;      // Take jump or branch target
        logic       regJmp;     // Target base is Rs instead of PC+2
        logic       memEnable;  // Data memory access
        logic       memWr;      // Data memory store
        logic [4:0] aluCntrl;   // Opcode seen by the ALU
        logic       val2Reg;    // Write back memory data
        logic       aluSel;     // Immediate as second operand
        logic [2:0] immSel;     // {sign, size} with size 00 5b, 01 8b, 10 11b
        logic       halt;
        logic [1:0] linkReg;    // 00 none, 01 LBI, 10 link
    } ctrlT;

    typedef struct packed {
        wordT       rsVal;
        wordT       rtVal;
        wordT       imm;        // Already extended
        regIdxT     destReg;
        logic [1:0] func;
        wordT       pc;
    } operandT;

    typedef struct packed {
        wordT aluOut;
        wordT storeData;
        wordT pcPlus2;
        wordT nextPc;
    } execResT;

    typedef struct packed {
        wordT   pc;
        wordT   nextPc;
        logic   wbEn;
        regIdxT wbReg;
        wordT   wbData;
        logic   memWr;
        wordT   memAddr;        // Byte address from the ALU
        wordT   memData;        // Store data or load result
        logic   halt;
    } retireT;

endpackage

// ==== source/coreCfg.svh ====
// The 16-bit instruction formats fix CORE_XLEN at 16 and the 3-bit register fields fix CORE_NREGS at 8
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define CORE_XLEN       16  // Data and instruction word width
`define CORE_NREGS      8   // Architectural registers R0..R7
`define CORE_DMEM_WORDS 64  // Word data memory, indexed by address bits [6:1]

`endif
